//--- Makefile
# Verilator build and run of the core testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
		-f project.f -Mdir obj_dir -o sim_cpu
	./obj_dir/sim_cpu > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- logic/alu.sv
// ALU with one registered stage for add/sub/slt
// and a two-stage multiplier for the low 16 bits of the product
// z follows the op of the previous cycle
`timescale 1ns/1ps
`default_nettype none

module alu import isa_pkg::*; (
    input  logic    clk,
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   z
);

    alu_op_t     op_q;      // op of the last registered result
    word_t       arith_q;   // add / sub / slt result
    logic [15:0] pp_lo;     // a * b[7:0], low 16 bits
    logic [7:0]  pp_hi;     // a * b[15:8], only low 8 bits reach the result
    logic [15:0] prod_q;    // low product, stage 2

    // ##############################
    // stage 1
    // ##############################

    always_ff @(posedge clk) begin
        op_q <= op;
        case (op)
            ALU_ADD: arith_q <= a + b;
            ALU_SUB: arith_q <= a - b;
            ALU_SLT: arith_q <= (a < b) ? 16'sd1 : 16'sd0;   // signed compare
            default: arith_q <= '0;
        endcase
        // low half of a signed product equals the unsigned one
        pp_lo <= a * b[7:0];
        pp_hi <= a[7:0] * b[15:8];
    end

    // ##############################
    // stage 2
    // ##############################

    always_ff @(posedge clk) begin
        prod_q <= pp_lo + {pp_hi, 8'h00};   // partials realigned
    end

    // mult holds its operands through MULT_WAIT, so op_q is still MUL
    assign z = (op_q == ALU_MUL) ? word_t'(prod_q) : arith_q;

endmodule

`default_nettype wire

//--- logic/cpu_control.sv
// instruction FSM of the core: fetch, decode, execute, memory, writeback
// holds pc and the instruction register, picks ALU and writeback sources
// io_stall drops for one cycle after each UPDATE_PC
`timescale 1ns/1ps
`default_nettype none

module cpu_control import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_done,
    input  word_t    inst,
    input  logic     data_done,
    input  word_t    load_data,
    input  word_t    rs_val,
    input  word_t    rt_val,
    input  word_t    alu_z,
    output logic     fetch_start,
    output logic     data_start,
    output logic     data_write,
    output pc_t      ls_word_addr,
    output word_t    store_data,
    output pc_t      pc,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    output reg_idx_t wr_idx,
    output logic     wr_en,
    output word_t    wr_data,
    output word_t    alu_a,
    output word_t    alu_b,
    output alu_op_t  alu_op,
    output logic     io_stall
);

    typedef enum logic [3:0] {
        S_FETCH, S_FETCH_WAIT, S_DECODE, S_EXECUTE, S_MULT_WAIT,
        S_DATA_REQ, S_DATA_WAIT, S_WRITEBACK, S_UPDATE_PC
    } state_t;

    state_t   state, next_state;
    word_t    ir;          // latched instruction word
    opcode_t  opcode;
    logic     func;
    reg_idx_t rd_idx;
    word_t    imm_ext;
    logic     branch_eq;

    // ##############################
    // decode
    // ##############################

    assign opcode  = opcode_t'(ir[15:13]);
    assign rs_idx  = ir[12:9];
    assign rt_idx  = ir[8:5];
    assign rd_idx  = ir[4:1];
    assign func    = ir[0];
    assign imm_ext = {{(16 - IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]};   // sext imm5

    always_ff @(posedge clk) begin
        if (fetch_done)
            ir <= inst;
    end

    // ##############################
    // FSM
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= S_FETCH;   // first fetch right after reset
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            S_FETCH:      next_state = S_FETCH_WAIT;
            S_FETCH_WAIT: if (fetch_done) next_state = S_DECODE;
            S_DECODE: begin
                case (opcode)
                    OP_ARITH, OP_CMPMUL, OP_STORE, OP_LOAD: next_state = S_EXECUTE;
                    default: next_state = S_UPDATE_PC;   // jump, beq, 110, 111
                endcase
            end
            S_EXECUTE: begin
                if (opcode == OP_STORE || opcode == OP_LOAD)
                    next_state = S_DATA_REQ;   // alu_z holds the word address next cycle
                else if (opcode == OP_CMPMUL && !func)
                    next_state = S_MULT_WAIT;  // second multiplier stage
                else
                    next_state = S_WRITEBACK;
            end
            S_MULT_WAIT:  next_state = S_WRITEBACK;
            S_DATA_REQ:   next_state = S_DATA_WAIT;
            S_DATA_WAIT: begin
                if (data_done)
                    next_state = (opcode == OP_LOAD) ? S_WRITEBACK : S_UPDATE_PC;
            end
            S_WRITEBACK:  next_state = S_UPDATE_PC;
            S_UPDATE_PC:  next_state = S_FETCH;
            default:      next_state = S_FETCH;
        endcase
    end

    // ##############################
    // operands and ALU
    // ##############################

    always_comb begin
        case (opcode)
            OP_ARITH:  alu_op = func ? ALU_ADD : ALU_SUB;
            OP_CMPMUL: alu_op = func ? ALU_SLT : ALU_MUL;
            default:   alu_op = ALU_ADD;   // rs + imm for load/store
        endcase
    end

    assign alu_a = rs_val;
    assign alu_b = (opcode == OP_ARITH || opcode == OP_CMPMUL) ? rt_val : imm_ext;

    // memory strobes
    assign fetch_start  = (state == S_FETCH);
    assign data_start   = (state == S_DATA_REQ);
    assign data_write   = (opcode == OP_STORE);
    assign ls_word_addr = pc_t'(alu_z);   // low 12 bits of rs + imm
    assign store_data   = rt_val;

    // writeback, load writes rt, the others rd
    assign wr_en   = (state == S_WRITEBACK);
    assign wr_idx  = (opcode == OP_LOAD) ? rt_idx : rd_idx;
    assign wr_data = (opcode == OP_LOAD) ? load_data : alu_z;

    // ##############################
    // pc and io_stall
    // ##############################

    assign branch_eq = (rs_val == rt_val);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (state == S_UPDATE_PC) begin
            if (opcode == OP_JUMP)
                pc <= ir[11:0];                              // low 12 of 13-bit field
            else if (opcode == OP_BEQ && branch_eq)
                pc <= pc + 12'd1 + pc_t'(imm_ext);           // wraps in 12 bits
            else
                pc <= pc + 12'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            io_stall <= 1'b1;
        else
            io_stall <= (state != S_UPDATE_PC);   // low the cycle after UPDATE_PC
    end

    // every instruction takes more than one cycle, so no back to back retire
    a_stall_single: assert property (@(posedge clk) disable iff (!rst_n)
        !io_stall |=> io_stall);

endmodule

`default_nettype wire

//--- logic/cpu_top.sv
// top level of the 16-bit multicycle core
// ties the control FSM, register file, ALU and memory access unit together
// instruction and data memories hang off plain req/ack ports
`timescale 1ns/1ps
`default_nettype none

module cpu_top import isa_pkg::*, mem_pkg::*; #(
    parameter bus_addr_t INST_BASE = DEFAULT_INST_BASE,
    parameter bus_addr_t DATA_BASE = DEFAULT_DATA_BASE
) (
    input  logic      clk,
    input  logic      rst_n,
    output logic      io_stall,    // low one cycle per retired instruction
    // instruction side
    output logic      imem_req,
    output bus_addr_t imem_addr,
    input  logic      imem_ack,
    input  word_t     imem_rdata,
    // data side
    output logic      dmem_req,
    output bus_addr_t dmem_addr,
    output logic      dmem_we,
    output word_t     dmem_wdata,
    input  logic      dmem_ack,
    input  word_t     dmem_rdata
);

    // control <-> memory access unit
    logic     fetch_start, fetch_done;
    logic     data_start, data_done, data_write;
    word_t    inst, load_data, store_data;
    pc_t      pc, ls_word_addr;

    // control <-> register file
    reg_idx_t rs_idx, rt_idx, wr_idx;
    logic     wr_en;
    word_t    wr_data, rs_val, rt_val;

    // control <-> ALU
    word_t    alu_a, alu_b, alu_z;
    alu_op_t  alu_op;

    cpu_control u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_done   (fetch_done),
        .inst         (inst),
        .data_done    (data_done),
        .load_data    (load_data),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .alu_z        (alu_z),
        .fetch_start  (fetch_start),
        .data_start   (data_start),
        .data_write   (data_write),
        .ls_word_addr (ls_word_addr),
        .store_data   (store_data),
        .pc           (pc),
        .rs_idx       (rs_idx),
        .rt_idx       (rt_idx),
        .wr_idx       (wr_idx),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_op       (alu_op),
        .io_stall     (io_stall)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .wr_idx  (wr_idx),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_val  (rs_val),
        .rt_val  (rt_val)
    );

    alu u_alu (
        .clk (clk),
        .a   (alu_a),
        .b   (alu_b),
        .op  (alu_op),
        .z   (alu_z)
    );

    mem_access_unit #(
        .INST_BASE (INST_BASE),
        .DATA_BASE (DATA_BASE)
    ) u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_start  (fetch_start),
        .pc           (pc),
        .data_start   (data_start),
        .data_write   (data_write),
        .ls_word_addr (ls_word_addr),
        .store_data   (store_data),
        .fetch_done   (fetch_done),
        .inst         (inst),
        .data_done    (data_done),
        .load_data    (load_data),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_ack     (imem_ack),
        .imem_rdata   (imem_rdata),
        .dmem_req     (dmem_req),
        .dmem_addr    (dmem_addr),
        .dmem_we      (dmem_we),
        .dmem_wdata   (dmem_wdata),
        .dmem_ack     (dmem_ack),
        .dmem_rdata   (dmem_rdata)
    );

endmodule

`default_nettype wire

//--- logic/isa_pkg.sv
// instruction set definitions for the 16-bit multicycle core
// opcodes, field types and ALU operation codes
// imported by the control path, register file, ALU and the reference model
`default_nettype none

package isa_pkg;

    // ##############################
    // basic types
    // ##############################

    typedef logic signed [15:0] word_t;   // one data word, signed
    typedef logic [11:0] pc_t;            // instruction word address
    typedef logic [3:0] reg_idx_t;        // r0 .. r15

    localparam int IMM_W = 5;             // imm field, bits 4..0

    // ##############################
    // opcodes, bits 15..13
    // ##############################

    // 110 and 111 are not listed, they only advance pc
    typedef enum logic [2:0] {
        OP_ARITH  = 3'b000,   // func 1 add, func 0 sub
        OP_CMPMUL = 3'b001,   // func 1 slt, func 0 mult
        OP_STORE  = 3'b010,
        OP_LOAD   = 3'b011,
        OP_JUMP   = 3'b100,
        OP_BEQ    = 3'b101
    } opcode_t;

    // ##############################
    // ALU operations
    // ##############################

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,   // also load/store address
        ALU_SUB = 2'd1,
        ALU_MUL = 2'd2,   // low 16 bits of product
        ALU_SLT = 2'd3    // signed compare, 1 or 0
    } alu_op_t;

endpackage

`default_nettype wire

//--- logic/mem_access_unit.sv
// request sequencing for the instruction and data memories
// start pulse -> req held with a stable address until ack -> done pulse
// byte address is word address * 2 plus the side's base
`timescale 1ns/1ps
`default_nettype none

module mem_access_unit import isa_pkg::*, mem_pkg::*; #(
    parameter bus_addr_t INST_BASE = DEFAULT_INST_BASE,
    parameter bus_addr_t DATA_BASE = DEFAULT_DATA_BASE
) (
    input  logic      clk,
    input  logic      rst_n,
    // control side
    input  logic      fetch_start,
    input  pc_t       pc,
    input  logic      data_start,
    input  logic      data_write,
    input  pc_t       ls_word_addr,
    input  word_t     store_data,
    output logic      fetch_done,
    output word_t     inst,
    output logic      data_done,
    output word_t     load_data,
    // memory side
    output logic      imem_req,
    output bus_addr_t imem_addr,
    input  logic      imem_ack,
    input  word_t     imem_rdata,
    output logic      dmem_req,
    output bus_addr_t dmem_addr,
    output logic      dmem_we,
    output word_t     dmem_wdata,
    input  logic      dmem_ack,
    input  word_t     dmem_rdata
);

    // ##############################
    // instruction side
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            imem_req   <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= imem_req && imem_ack;   // pulse the cycle after ack
            if (fetch_start)
                imem_req <= 1'b1;
            else if (imem_ack)
                imem_req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start)
            imem_addr <= {19'd0, pc, 1'b0} + INST_BASE;
        if (imem_req && imem_ack)
            inst <= imem_rdata;
    end

    // ##############################
    // data side
    // ##############################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmem_req  <= 1'b0;
            dmem_we   <= 1'b0;
            data_done <= 1'b0;
        end else begin
            data_done <= dmem_req && dmem_ack;
            if (data_start) begin
                dmem_req <= 1'b1;
                dmem_we  <= data_write;   // kept until the next request
            end else if (dmem_ack) begin
                dmem_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_start) begin
            dmem_addr  <= {19'd0, ls_word_addr, 1'b0} + DATA_BASE;
            dmem_wdata <= store_data;
        end
        if (dmem_req && dmem_ack && !dmem_we)
            load_data <= dmem_rdata;   // held for WRITEBACK
    end

    // ##############################
    // memory protocol checks
    // ##############################

    a_imem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req && !imem_ack |=> imem_req && $stable(imem_addr));
    a_dmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req && !dmem_ack |=> dmem_req && $stable(dmem_addr)
            && $stable(dmem_we) && $stable(dmem_wdata));
    a_imem_ack: assert property (@(posedge clk) disable iff (!rst_n)
        imem_ack |-> imem_req);
    a_dmem_ack: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_ack |-> dmem_req);

endmodule

`default_nettype wire

//--- logic/mem_pkg.sv
// memory side types and address map defaults
// byte address = word address * 2 + base, one base per memory side
// imported by the top level, the memory access unit and the testbench
`default_nettype none

package mem_pkg;

    // ##############################
    // bus types
    // ##############################

    typedef logic [31:0] bus_addr_t;   // byte address on either side

    // ##############################
    // address map
    // ##############################

    // both sides start at 0x1000 unless the top level overrides them
    localparam bus_addr_t DEFAULT_INST_BASE = 32'h0000_1000;
    localparam bus_addr_t DEFAULT_DATA_BASE = 32'h0000_1000;

endpackage

`default_nettype wire

//--- logic/reg_file.sv
// sixteen signed 16-bit registers
// two combinational read ports, one write port landing on the next edge
`timescale 1ns/1ps
`default_nettype none

module reg_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  reg_idx_t wr_idx,
    input  logic     wr_en,
    input  word_t    wr_data,
    output word_t    rs_val,
    output word_t    rt_val
);

    localparam int NUM_REGS = 16;

    word_t regs [NUM_REGS];   // r0 is an ordinary register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // no bypass, writeback and the next read never share a cycle
    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];

endmodule

`default_nettype wire

//--- project.f
+incdir+verification
logic/isa_pkg.sv
logic/mem_pkg.sv
logic/reg_file.sv
logic/alu.sv
logic/mem_access_unit.sv
logic/cpu_control.sv
logic/cpu_top.sv
verification/tb_cpu.sv

//--- verification/cpu_model.svh
// instruction set reference model and random program generator
// included inside the core testbench to fill prog[] and the expected access queues
// model state (m_regs, m_mem) is kept apart from the responding memories
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int PROG_LEN = 200;   // last slot holds the self-jump

word_t     m_regs [16];
word_t     m_mem  [4096];        // model copy of data memory
bus_addr_t exp_fetch [$];        // fetch byte addresses in order
bus_addr_t exp_st_addr [$];
word_t     exp_st_data [$];
bus_addr_t exp_ld_addr [$];
int        exp_retired;          // instructions before the self-jump

// imm5 is two's complement, values from half the range up are negative
function automatic word_t sext_imm(input word_t ins);
    int v;
    v = int'(ins[IMM_W-1:0]);
    if (v >= (1 << (IMM_W - 1)))
        v = v - (1 << IMM_W);
    return word_t'(v);
endfunction

function automatic word_t make_rtype(input logic [2:0] op, input int rs, input int rt,
                                     input int rd, input bit func);
    return word_t'({op, 4'(rs), 4'(rt), 4'(rd), func});
endfunction

function automatic word_t make_itype(input logic [2:0] op, input int rs, input int rt,
                                     input int imm);
    return word_t'({op, 4'(rs), 4'(rt), 5'(imm)});
endfunction

function automatic int pick_reg();
    return $urandom_range(15, 0);
endfunction

// ##############################
// program generator
// ##############################

function automatic void gen_program();
    int i;
    int kind;
    int rd;
    int span;
    int st_rs;                            // base and offset of the latest store
    int st_imm;
    i = 0;
    st_rs  = 0;
    st_imm = 0;
    // r1..r15 loaded off r0 while it is still zero and r0 itself last
    for (int r = 1; r < 16; r++) begin
        prog[i] = make_itype(OP_LOAD, 0, r, $urandom_range(31, 0));
        i++;
    end
    prog[i] = make_itype(OP_LOAD, 0, 0, $urandom_range(31, 0));
    i++;
    while (i < PROG_LEN - 1) begin
        kind = $urandom_range(7, 0);
        span = PROG_LEN - 2 - i;          // farthest forward step inside the program
        if (span > 3)
            span = 3;
        if (kind < 4 && i > PROG_LEN - 3)
            kind = 5;                     // no slot left for the checking store
        case (kind)
            0, 1, 2, 3: begin             // sub, add, mult, slt
                rd = pick_reg();
                prog[i] = make_rtype(kind < 2 ? OP_ARITH : OP_CMPMUL, pick_reg(),
                                     pick_reg(), rd, kind[0]);
                st_rs  = pick_reg();
                st_imm = $urandom_range(31, 0);
                prog[i+1] = make_itype(OP_STORE, st_rs, rd, st_imm);
                i += 2;
            end
            4: begin
                if ($urandom_range(1, 0) == 1)   // read back the latest stored word
                    prog[i] = make_itype(OP_LOAD, st_rs, pick_reg(), st_imm);
                else
                    prog[i] = make_itype(OP_LOAD, pick_reg(), pick_reg(),
                                         $urandom_range(31, 0));
                i++;
            end
            5: begin
                st_rs  = pick_reg();
                st_imm = $urandom_range(31, 0);
                prog[i] = make_itype(OP_STORE, st_rs, pick_reg(), st_imm);
                i++;
            end
            6: begin
                rd = pick_reg();          // rs with rt equal to it half the time
                prog[i] = make_itype(OP_BEQ, rd, ($urandom_range(1, 0) == 1) ? rd : pick_reg(),
                                     $urandom_range(span, 0));
                i++;
            end
            default: begin                // forward jump only
                prog[i] = word_t'({OP_JUMP, 1'b0, 12'(i + 1 + $urandom_range(span, 0))});
                i++;
            end
        endcase
    end
    prog[PROG_LEN-1] = word_t'({OP_JUMP, 1'b0, 12'(PROG_LEN - 1)});
endfunction

// ##############################
// reference model
// ##############################

function automatic void run_model();
    int          pc;
    word_t       ins, a, b;
    logic [11:0] waddr;
    pc = 0;
    exp_retired = 0;
    for (int r = 0; r < 16; r++)
        m_regs[r] = '0;               // registers clear on reset
    while (pc != PROG_LEN - 1) begin
        ins   = prog[pc];
        a     = m_regs[ins[12:9]];
        b     = m_regs[ins[8:5]];
        waddr = 12'(a + sext_imm(ins));   // low 12 bits of rs + imm
        exp_fetch.push_back(INST_BASE + bus_addr_t'(pc) * 2);
        case (opcode_t'(ins[15:13]))
            OP_ARITH:  m_regs[ins[4:1]] = ins[0] ? a + b : a - b;
            OP_CMPMUL: m_regs[ins[4:1]] = ins[0] ? ((a < b) ? 16'sd1 : 16'sd0) : a * b;
            OP_STORE: begin
                m_mem[waddr] = b;
                exp_st_addr.push_back(DATA_BASE + bus_addr_t'(waddr) * 2);
                exp_st_data.push_back(b);
            end
            OP_LOAD: begin
                m_regs[ins[8:5]] = m_mem[waddr];
                exp_ld_addr.push_back(DATA_BASE + bus_addr_t'(waddr) * 2);
            end
            default: ;
        endcase
        if (ins[15:13] == 3'b100)
            pc = int'(ins[11:0]);
        else if (ins[15:13] == 3'b101 && a == b)
            pc = (pc + 1 + int'(sext_imm(ins))) & 4095;
        else
            pc = pc + 1;
        exp_retired++;
    end
    exp_fetch.push_back(INST_BASE + bus_addr_t'(pc) * 2);   // the self-jump
endfunction

`endif

//--- verification/tb_cpu.sv
// testbench for the 16-bit multicycle core
// runs a random program against the reference model in cpu_model.svh
// two responders play instruction and data memory with random latency
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
    import isa_pkg::*, mem_pkg::*;
();

    localparam bus_addr_t INST_BASE     = DEFAULT_INST_BASE;
    localparam bus_addr_t DATA_BASE     = DEFAULT_DATA_BASE;
    localparam int        RUN_TIMEOUT   = 20000;   // cycles to reach the self-jump
    localparam int        FETCH_TIMEOUT = 200;
    localparam int        DATA_TIMEOUT  = 1000;

    logic      clk, rst_n, io_stall;
    logic      imem_req, imem_ack, dmem_req, dmem_we, dmem_ack;
    bus_addr_t imem_addr, dmem_addr;
    word_t     imem_rdata, dmem_rdata, dmem_wdata;

    word_t     prog [4096];   // instruction memory image
    word_t     dmem [4096];   // data memory seen by the DUT
    int        retired, checks, errors;
    int        spin_fetches;  // fetches past the end of the model trace
    bit        end_seen;      // self-jump fetched

    `include "cpu_model.svh"

    cpu_top #(
        .INST_BASE (INST_BASE),
        .DATA_BASE (DATA_BASE)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .io_stall   (io_stall),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wdata (dmem_wdata),
        .dmem_ack   (dmem_ack),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ##############################
    // helpers
    // ##############################

    task automatic next_cycle();   // 2 ns past the rising edge
        @(posedge clk);
        #2;
    endtask

    task automatic compare_value(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s: expected %h, actual %h at %0t", test, exp, act, $time);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s at %0t", msg, $time);
    endtask

    // ##############################
    // memory responders
    // ##############################

    initial begin : imem_responder
        int        idle;
        bus_addr_t addr;
        next_cycle();
        forever begin
            idle = 0;
            while (!imem_req && idle < FETCH_TIMEOUT) begin
                next_cycle();
                if (rst_n)
                    idle++;           // reset cycles do not count
            end
            if (!imem_req) begin
                report_failure("no instruction fetch within the timeout");
            end else begin
                addr = imem_addr;
                if (exp_fetch.size() > 0) begin
                    compare_value("fetch address", exp_fetch.pop_front(), addr);
                    if (exp_fetch.size() == 0)
                        end_seen = 1'b1;
                end else begin
                    // past the end the core spins on the self-jump
                    compare_value("self-jump fetch",
                                  INST_BASE + bus_addr_t'(PROG_LEN - 1) * 2, addr);
                    spin_fetches++;
                end
                repeat ($urandom_range(6, 1)) next_cycle();
                imem_rdata = prog[12'((addr - INST_BASE) >> 1)];
                imem_ack   = 1'b1;
                next_cycle();
                imem_ack   = 1'b0;
                if (imem_req)
                    report_failure("instruction request still high the cycle after ack");
            end
        end
    end

    initial begin : dmem_responder
        int          idle;
        bus_addr_t   addr;
        logic [11:0] idx;
        next_cycle();
        forever begin
            idle = 0;
            while (!dmem_req && idle < DATA_TIMEOUT) begin
                next_cycle();
                if (rst_n)
                    idle++;
            end
            if (!dmem_req) begin
                // quiet stretches are fine once the model has no traffic left
                if (exp_st_addr.size() + exp_ld_addr.size() != 0)
                    report_failure("no data request within the timeout");
            end else begin
                addr = dmem_addr;
                idx  = 12'((addr - DATA_BASE) >> 1);
                if (dmem_we) begin
                    if (exp_st_addr.size() == 0) begin
                        report_failure("store issued but the model has none left");
                    end else begin
                        compare_value("store address", exp_st_addr.pop_front(), addr);
                        compare_value("store data", exp_st_data.pop_front(), dmem_wdata);
                    end
                    dmem[idx] = dmem_wdata;
                end else if (exp_ld_addr.size() == 0) begin
                    report_failure("load issued but the model has none left");
                end else begin
                    compare_value("load address", exp_ld_addr.pop_front(), addr);
                end
                repeat ($urandom_range(6, 1)) next_cycle();
                dmem_rdata = dmem[idx];
                dmem_ack   = 1'b1;
                next_cycle();
                dmem_ack   = 1'b0;
                if (dmem_req)
                    report_failure("data request still high the cycle after ack");
            end
        end
    end

    // one low cycle per retired instruction and never two in a row
    initial begin : stall_monitor
        bit was_low;
        was_low = 1'b0;
        forever begin
            next_cycle();
            if (rst_n) begin
                if (!io_stall && was_low)
                    report_failure("io_stall low for two cycles in a row");
                if (!io_stall && !end_seen)
                    retired++;
                was_low = !io_stall;
            end
        end
    end

    // ##############################
    // main sequence
    // ##############################

    initial begin : main
        int cycles;
        void'($urandom(67));
        rst_n        = 1'b0;
        imem_ack     = 1'b0;
        imem_rdata   = '0;
        dmem_ack     = 1'b0;
        dmem_rdata   = '0;
        checks       = 0;
        errors       = 0;
        retired      = 0;
        spin_fetches = 0;
        end_seen     = 1'b0;
        for (int k = 0; k < 4096; k++) begin
            prog[k]  = word_t'({3'b111, 1'b0, 12'(k)});   // opcode 111 fill only advances pc
            dmem[k]  = word_t'($urandom);
            m_mem[k] = dmem[k];
        end
        gen_program();
        run_model();

        for (int c = 0; c < 10; c++) begin
            next_cycle();
            if (io_stall !== 1'b1 || imem_req !== 1'b0 || dmem_req !== 1'b0)
                report_failure("outputs not at their reset values while rst_n is low");
        end
        rst_n = 1'b1;

        cycles = 0;
        while (!end_seen && cycles < RUN_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!end_seen) begin
            report_failure("program did not reach its final self-jump in time");
        end else begin
            cycles = 0;
            while (spin_fetches == 0 && cycles < FETCH_TIMEOUT) begin
                next_cycle();
                cycles++;
            end
            if (spin_fetches == 0)
                report_failure("self-jump did not fetch itself again in time");
            compare_value("retired count", exp_retired, retired);
            if (exp_st_addr.size() + exp_ld_addr.size() != 0)
                report_failure("model data accesses never seen on the data side");
        end

        $display("checks %0d, errors %0d, retired %0d", checks, errors, retired);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
